/* verilog/ddr_pkg.sv */
package ddr_pkg;

   ///////////////////////////////
   // user port widths
   ///////////////////////////////
   localparam int byte_w     = 8;
   localparam int word_w     = 128;
   localparam int word_bytes = 16;   // also the write address step
   localparam int mask_w     = 16;
   localparam int addr_w     = 30;
   localparam int bl_w       = 6;
   localparam int instr_w    = 3;

   // command codes
   localparam logic [instr_w-1:0] cmd_write = 3'b010;
   localparam logic [instr_w-1:0] cmd_read  = 3'b001;

   // burst length field is words minus one
   localparam logic [bl_w-1:0] wr_bl = 6'd0;    // one word
   localparam logic [bl_w-1:0] rd_bl = 6'd63;   // 64 words

   localparam logic [addr_w-1:0] rd_base_addr = 30'd16;
   localparam logic [addr_w-1:0] rd_step      = 30'd1024;   // 64 words of 16 bytes

   ///////////////////////////////
   // fsm encodings
   ///////////////////////////////
   localparam logic [2:0] ws_idle      = 3'd0;
   localparam logic [2:0] ws_fill      = 3'd1;
   localparam logic [2:0] ws_data_done = 3'd2;
   localparam logic [2:0] ws_cmd_setup = 3'd3;
   localparam logic [2:0] ws_cmd_issue = 3'd4;
   localparam logic [2:0] ws_done      = 3'd5;

   localparam logic [1:0] rs_idle      = 2'd0;
   localparam logic [1:0] rs_cmd_setup = 2'd1;
   localparam logic [1:0] rs_cmd_issue = 2'd2;
   localparam logic [1:0] rs_done      = 2'd3;

   // port 0 command bundle
   typedef struct packed {
      logic               en;
      logic [instr_w-1:0] instr;
      logic [bl_w-1:0]    bl;
      logic [addr_w-1:0]  byte_addr;
   } mcb_cmd_t;

   // port 0 write data bundle
   typedef struct packed {
      logic              en;
      logic [mask_w-1:0] mask;
      logic [word_w-1:0] data;
   } mcb_wr_t;

endpackage

/* verilog/byte_packer.sv */
`timescale 1ns/1ps

module byte_packer
   import ddr_pkg::*;
(
   input  logic              c3_clk0,
   input  logic              rst_n,
   input  logic              calib_done,
   input  logic [byte_w-1:0] byte_data,
   input  logic              byte_valid,
   output logic [word_w-1:0] word,
   output logic              word_valid
);

   logic [$clog2(word_bytes)-1:0] byte_cnt;
   logic [word_w-byte_w-1:0]      hold;    // first 15 bytes of the word
   logic                          last_byte;

   assign last_byte = byte_valid && (byte_cnt == word_bytes - 1);

   ///////////////////////////////
   // strobe counter
   ///////////////////////////////
   always_ff @(posedge c3_clk0 or negedge rst_n) begin
      if (!rst_n) begin
         byte_cnt   <= '0;
         word_valid <= 1'b0;
      end else if (!calib_done) begin
         byte_cnt   <= '0;
         word_valid <= 1'b0;
      end else begin
         word_valid <= last_byte;   // one cycle per full word
         if (byte_valid) begin
            byte_cnt <= byte_cnt + 1'b1;   // wraps to 0 after the 16th
         end
      end
   end

   // byte shifter puts the first byte in the top byte
   always_ff @(posedge c3_clk0) begin
      if (!calib_done) begin
         hold <= '0;
      end else if (last_byte) begin
         word <= {hold, byte_data};
         hold <= '0;
      end else if (byte_valid) begin
         hold <= {hold[word_w-2*byte_w-1:0], byte_data};
      end
   end

endmodule

/* verilog/ddr_write_ctrl.sv */
`timescale 1ns/1ps

module ddr_write_ctrl
   import ddr_pkg::*;
(
   input  logic              c3_clk0,
   input  logic              rst_n,
   input  logic              calib_done,
   input  logic [word_w-1:0] word,
   input  logic              word_valid,
   input  logic              wr_full,
   input  logic              cmd_full,
   output mcb_wr_t           wr,
   output mcb_cmd_t          wr_cmd,
   output logic              write_busy
);

   logic [2:0]        state;
   logic              wr_en_q;
   logic [word_w-1:0] wr_data_q;
   logic              take_word;

   // words arriving while busy are dropped
   assign take_word = calib_done && (state == ws_idle) && word_valid;

   assign wr = '{en: wr_en_q, mask: '0, data: wr_data_q};

   ///////////////////////////////
   // write fsm
   ///////////////////////////////
   always_ff @(posedge c3_clk0 or negedge rst_n) begin
      if (!rst_n) begin
         state      <= ws_idle;
         wr_en_q    <= 1'b0;
         write_busy <= 1'b0;
         wr_cmd     <= '0;   // address starts at 0
      end else if (!calib_done) begin
         state      <= ws_idle;
         wr_en_q    <= 1'b0;
         write_busy <= 1'b0;
         wr_cmd     <= '0;
      end else begin
         case (state)
            ws_idle: begin
               if (word_valid) begin
                  write_busy <= 1'b1;
                  state      <= ws_fill;
               end
            end

            ws_fill: begin
               if (!wr_full) begin   // wait for room in the write fifo
                  wr_en_q <= 1'b1;
                  state   <= ws_data_done;
               end
            end

            ws_data_done: begin
               wr_en_q <= 1'b0;
               state   <= ws_cmd_setup;
            end

            ws_cmd_setup: begin
               wr_cmd.instr     <= cmd_write;
               wr_cmd.bl        <= wr_bl;
               wr_cmd.byte_addr <= wr_cmd.byte_addr + addr_w'(word_bytes);
               state            <= ws_cmd_issue;
            end

            ws_cmd_issue: begin
               if (!cmd_full) begin
                  wr_cmd.en <= 1'b1;   // single cycle push
                  state     <= ws_done;
               end
            end

            ws_done: begin
               wr_cmd.en  <= 1'b0;
               write_busy <= 1'b0;
               state      <= ws_idle;
            end

            default: begin
               wr_en_q   <= 1'b0;
               wr_cmd.en <= 1'b0;
               state     <= ws_idle;
            end
         endcase
      end
   end

   // data word held for the fifo push
   always_ff @(posedge c3_clk0) begin
      if (take_word) begin
         wr_data_q <= word;
      end
   end

endmodule

/* verilog/ddr_cmd_ctrl.sv */
`timescale 1ns/1ps

module ddr_cmd_ctrl
   import ddr_pkg::*;
(
   input  logic     c3_clk0,
   input  logic     rst_n,
   input  logic     calib_done,
   input  logic     pic_read_done,
   input  logic     write_busy,
   input  mcb_cmd_t wr_cmd,
   input  logic     rd_cmd,
   input  logic     addr_set,
   input  logic     rden,
   output mcb_cmd_t cmd,
   output logic     rd_en
);

   logic       pic_stored;   // picture in memory and no write in flight
   logic       rd_cmd_q1;
   logic       rd_cmd_q2;
   logic       rd_req;
   logic       rden_q1;
   logic       rden_q2;
   logic [1:0] state;
   mcb_cmd_t   rd_cmd_r;

   assign pic_stored = pic_read_done && !write_busy;

   ///////////////////////////////
   // rising edge detectors
   ///////////////////////////////
   always_ff @(posedge c3_clk0 or negedge rst_n) begin
      if (!rst_n) begin
         rd_cmd_q1 <= 1'b0;
         rd_cmd_q2 <= 1'b0;
         rd_req    <= 1'b0;
         rden_q1   <= 1'b0;
         rden_q2   <= 1'b0;
         rd_en     <= 1'b0;
      end else if (!calib_done) begin
         rd_cmd_q1 <= 1'b0;
         rd_cmd_q2 <= 1'b0;
         rd_req    <= 1'b0;
         rden_q1   <= 1'b0;
         rden_q2   <= 1'b0;
         rd_en     <= 1'b0;
      end else begin
         rd_cmd_q1 <= rd_cmd;
         rd_cmd_q2 <= rd_cmd_q1;
         rd_req    <= rd_cmd_q1 && !rd_cmd_q2;   // one burst per edge
         rden_q1   <= rden;
         rden_q2   <= rden_q1;
         rd_en     <= rden_q1 && !rden_q2;       // read fifo pop
      end
   end

   ///////////////////////////////
   // read burst fsm
   ///////////////////////////////
   always_ff @(posedge c3_clk0 or negedge rst_n) begin
      if (!rst_n) begin
         state    <= rs_idle;
         rd_cmd_r <= '{en: 1'b0, instr: '0, bl: '0, byte_addr: rd_base_addr};
      end else if (!calib_done) begin
         state    <= rs_idle;
         rd_cmd_r <= '{en: 1'b0, instr: '0, bl: '0, byte_addr: rd_base_addr};
      end else if (addr_set) begin
         // fsm holds its state while the address returns to the frame start
         rd_cmd_r.en        <= 1'b0;
         rd_cmd_r.byte_addr <= rd_base_addr;
      end else if (pic_stored) begin
         case (state)
            rs_idle: begin
               if (rd_req) begin
                  state <= rs_cmd_setup;
               end
            end

            rs_cmd_setup: begin
               rd_cmd_r.instr <= cmd_read;
               rd_cmd_r.bl    <= rd_bl;
               state          <= rs_cmd_issue;
            end

            // cmd_full is not checked for reads
            rs_cmd_issue: begin
               rd_cmd_r.en <= 1'b1;
               state       <= rs_done;
            end

            rs_done: begin
               rd_cmd_r.en        <= 1'b0;
               rd_cmd_r.byte_addr <= rd_cmd_r.byte_addr + rd_step;   // next 64 words
               state              <= rs_idle;
            end
         endcase
      end
   end

   ///////////////////////////////
   // command port owner
   ///////////////////////////////
   always_comb begin
      if (pic_stored) begin
         cmd = rd_cmd_r;
      end else begin
         cmd = wr_cmd;   // writer owns the port until the picture is in
      end
   end

endmodule

/* verilog/ddr_frame_top.sv */
`timescale 1ns/1ps

module ddr_frame_top
   import ddr_pkg::*;
(
   input  logic              c3_clk0,
   input  logic              rst_n,
   input  logic              calib_done,

   // image source
   input  logic [byte_w-1:0] byte_data,
   input  logic              byte_valid,
   input  logic              pic_read_done,

   // display side requests
   input  logic              rd_cmd,
   input  logic              addr_set,
   input  logic              rden,

   // user port 0
   input  logic              cmd_full,
   input  logic              wr_full,
   output mcb_cmd_t          cmd,
   output mcb_wr_t           wr,
   output logic              rd_en
);

   logic [word_w-1:0] word;
   logic              word_valid;
   mcb_cmd_t          wr_cmd;
   logic              write_busy;

   ///////////////////////////////
   // write path
   ///////////////////////////////
   byte_packer byte_packer_i (
      .c3_clk0    (c3_clk0),
      .rst_n      (rst_n),
      .calib_done (calib_done),
      .byte_data  (byte_data),
      .byte_valid (byte_valid),
      .word       (word),
      .word_valid (word_valid)
   );

   ddr_write_ctrl ddr_write_ctrl_i (
      .c3_clk0    (c3_clk0),
      .rst_n      (rst_n),
      .calib_done (calib_done),
      .word       (word),
      .word_valid (word_valid),
      .wr_full    (wr_full),
      .cmd_full   (cmd_full),
      .wr         (wr),
      .wr_cmd     (wr_cmd),
      .write_busy (write_busy)
   );

   // read bursts and port arbitration
   ddr_cmd_ctrl ddr_cmd_ctrl_i (
      .c3_clk0       (c3_clk0),
      .rst_n         (rst_n),
      .calib_done    (calib_done),
      .pic_read_done (pic_read_done),
      .write_busy    (write_busy),
      .wr_cmd        (wr_cmd),
      .rd_cmd        (rd_cmd),
      .addr_set      (addr_set),
      .rden          (rden),
      .cmd           (cmd),
      .rd_en         (rd_en)
   );

endmodule

/* test/mcb_port_model.sv */
`timescale 1ns/1ps

module mcb_port_model
   import ddr_pkg::*;
(
   input  logic     c3_clk0,
   input  mcb_cmd_t cmd,
   input  mcb_wr_t  wr,
   input  logic     wr_hold,
   input  logic     cmd_hold,
   output logic     wr_full,
   output logic     cmd_full
);

   mcb_wr_t  word_q[$];
   mcb_cmd_t cmd_q[$];

   // full flags come straight from the test
   assign wr_full  = wr_hold;
   assign cmd_full = cmd_hold;

   ///////////////////////////////
   // fifo push capture
   ///////////////////////////////
   always @(posedge c3_clk0) begin
      if (wr.en) begin
         word_q.push_back(wr);
      end
      if (cmd.en) begin
         cmd_q.push_back(cmd);   // reads and writes share this queue
      end
   end

   function automatic int word_count();
      return word_q.size();
   endfunction

   function automatic int cmd_count();
      return cmd_q.size();
   endfunction

   // caller checks the count first
   function automatic mcb_wr_t pop_word();
      return word_q.pop_front();
   endfunction

   function automatic mcb_cmd_t pop_cmd();
      return cmd_q.pop_front();
   endfunction

endmodule

/* test/tb_ddr_frame.sv */
`timescale 1ns/1ps

module tb_ddr_frame
   import ddr_pkg::*;
();

   localparam int clk_period    = 40;
   localparam int drive_dly     = 2;
   localparam int wait_limit    = 40;
   localparam int test_cycles   = 40 + 100 + 120 + 100 + 60;   // per-test budgets
   localparam int margin_cycles = 200;

   logic c3_clk0, rst_n, calib_done, byte_valid, pic_read_done;
   logic rd_cmd, addr_set, rden, wr_hold, cmd_hold, cmd_full, wr_full, rd_en;
   logic [byte_w-1:0] byte_data;
   mcb_cmd_t          cmd;
   mcb_wr_t           wr;
   logic [31:0]       lfsr;
   logic [addr_w-1:0] wr_addr_exp;

   always #(clk_period / 2) c3_clk0 = ~c3_clk0;

   ddr_frame_top dut_i (.*);

   mcb_port_model port_i (.c3_clk0, .cmd, .wr, .wr_hold, .cmd_hold, .wr_full, .cmd_full);

   ///////////////////////////////
   // helpers
   ///////////////////////////////
   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check(input string test, input logic [159:0] exp, input logic [159:0] act);
      if (exp !== act) begin
         fail_run($sformatf("[FAIL] %s: expected %0h, actual %0h", test, exp, act));
      end
   endtask

   task automatic tick();   // inputs change just after the edge
      @(posedge c3_clk0);
      #(drive_dly);
   endtask

   function automatic logic [byte_w-1:0] next_byte();
      logic [byte_w-1:0] b;
      b = '0;
      for (int i = 0; i < byte_w; i++) begin
         b    = {b[byte_w-2:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);   // galois step
      end
      return b;
   endfunction

   task automatic send_word(output logic [word_w-1:0] data);
      logic [byte_w-1:0] b;
      data = '0;
      for (int k = 0; k < word_bytes; k++) begin
         b          = next_byte();
         data       = {data[word_w-byte_w-1:0], b};   // first byte ends on top
         byte_data  = b;
         byte_valid = 1'b1;
         tick();
      end
      byte_valid = 1'b0;
   endtask

   // waits for a write word when words is set and for a command otherwise
   task automatic wait_for(input bit words, input string test);
      int waited;
      waited = 0;
      while ((words ? port_i.word_count() : port_i.cmd_count()) == 0 && waited < wait_limit) begin
         tick();
         waited++;
      end
      if ((words ? port_i.word_count() : port_i.cmd_count()) == 0) begin
         fail_run($sformatf("%s: nothing reached the port within %0d cycles", test, wait_limit));
      end
   endtask

   task automatic check_cmd(input string test, input logic [instr_w-1:0] instr,
                            input logic [bl_w-1:0] bl, input logic [addr_w-1:0] addr);
      mcb_cmd_t exp;
      exp.en        = 1'b1;
      exp.instr     = instr;
      exp.bl        = bl;
      exp.byte_addr = addr;
      if (port_i.cmd_count() == 0) begin
         fail_run($sformatf("%s: no command was recorded", test));
      end
      check(test, exp, port_i.pop_cmd());
   endtask

   task automatic check_write(input string test, input logic [word_w-1:0] data);
      mcb_wr_t exp;
      exp.en      = 1'b1;
      exp.mask    = '0;
      exp.data    = data;
      wr_addr_exp = wr_addr_exp + word_bytes;
      if (port_i.word_count() == 0) begin
         fail_run($sformatf("%s: no write word was recorded", test));
      end
      check(test, exp, port_i.pop_word());
      check_cmd(test, cmd_write, wr_bl, wr_addr_exp);
   endtask

   task automatic pulse_rd_cmd();
      rd_cmd = 1'b1;
      repeat (3) tick();
      rd_cmd = 1'b0;
      tick();
   endtask

   ///////////////////////////////
   // directed tests
   ///////////////////////////////
   task automatic test_reset_calib();
      logic [byte_w-1:0] b;
      for (int i = 0; i < 20; i++) begin
         b          = next_byte();
         byte_data  = b;
         byte_valid = 1'b1;
         rden       = (i >= 4 && i < 8);
         rd_cmd     = (i >= 4 && i < 8);
         tick();
         check("reset_calib wr.en", 0, wr.en);
         check("reset_calib cmd.en", 0, cmd.en);
         check("reset_calib rd_en", 0, rd_en);
      end
      byte_valid = 1'b0;
      calib_done = 1'b1;
      repeat (4) tick();
   endtask

   task automatic test_pack_write();
      logic [word_w-1:0] data;
      for (int w = 0; w < 3; w++) begin
         send_word(data);
         wait_for(1'b0, "pack_write");
         check_write("pack_write", data);
      end
   endtask

   task automatic test_write_backpressure();
      logic [word_w-1:0] data;
      wr_hold = 1'b1;
      send_word(data);
      repeat (20) begin
         tick();
         check("backpressure wr_full words", 0, port_i.word_count());
      end
      wr_hold  = 1'b0;
      cmd_hold = 1'b1;   // command side blocks once the data is in
      wait_for(1'b1, "backpressure data");
      repeat (20) begin
         tick();
         check("backpressure cmd_full cmds", 0, port_i.cmd_count());
      end
      cmd_hold = 1'b0;
      wait_for(1'b0, "backpressure cmd");
      repeat (10) tick();
      check("backpressure word total", 1, port_i.word_count());
      check("backpressure cmd total", 1, port_i.cmd_count());
      check_write("backpressure", data);
   endtask

   task automatic test_read_bursts();
      pulse_rd_cmd();   // picture not stored yet
      repeat (10) tick();
      check("read_bursts before store", 0, port_i.cmd_count());
      pic_read_done = 1'b1;
      tick();
      for (int k = 0; k < 2; k++) begin
         pulse_rd_cmd();
         wait_for(1'b0, "read_bursts");
         check_cmd("read_bursts", cmd_read, rd_bl, rd_base_addr + addr_w'(k) * rd_step);
      end
      repeat (3) tick();
      addr_set = 1'b1;
      repeat (2) tick();
      addr_set = 1'b0;
      tick();
      pulse_rd_cmd();
      wait_for(1'b0, "read_bursts addr_set");
      check_cmd("read_bursts addr_set", cmd_read, rd_bl, rd_base_addr);
      repeat (8) tick();
      check("read_bursts extra cmds", 0, port_i.cmd_count());
   endtask

   task automatic test_read_enable();
      for (int e = 0; e < 2; e++) begin
         rden = 1'b1;
         for (int i = 1; i <= 8; i++) begin
            tick();
            check($sformatf("read_enable edge %0d cycle %0d", e, i), (i == 2), rd_en);
         end
         rden = 1'b0;
         repeat (3) tick();
      end
   endtask

   initial begin
      c3_clk0       = 1'b0;
      rst_n         = 1'b0;
      calib_done    = 1'b0;
      byte_data     = '0;
      byte_valid    = 1'b0;
      pic_read_done = 1'b0;
      rd_cmd        = 1'b0;
      addr_set      = 1'b0;
      rden          = 1'b0;
      wr_hold       = 1'b0;
      cmd_hold      = 1'b0;
      lfsr          = 32'h29a57247;
      wr_addr_exp   = '0;
      repeat (3) tick();
      rst_n = 1'b1;
      tick();
      test_reset_calib();
      test_pack_write();
      test_write_backpressure();
      test_read_bursts();
      test_read_enable();
      $display("Simulation passed");
      $finish;
   end

   // watchdog
   initial begin
      #((test_cycles + margin_cycles) * clk_period);
      fail_run("watchdog: the tests did not finish in the expected time");
   end

endmodule

/* verilog.f */
verilog/ddr_pkg.sv
verilog/byte_packer.sv
verilog/ddr_write_ctrl.sv
verilog/ddr_cmd_ctrl.sv
verilog/ddr_frame_top.sv
test/mcb_port_model.sv
test/tb_ddr_frame.sv
